//--- life_pkg.sv
package life_pkg;

   // default grid size
   parameter int GRID_ROWS = 16;
   parameter int GRID_COLS = 16;

   // width of the generation count and of the programmed limit
   parameter int GEN_WIDTH = 16;

   // run controller states
   typedef enum logic [1:0] {
      ST_IDLE  = 2'd0,
      ST_RUN   = 2'd1,
      ST_PAUSE = 2'd2,
      ST_DONE  = 2'd3
   } run_state_t;

endpackage

//--- life_cell.sv
`timescale 1ns/1ps

module life_cell (
   input  logic [7:0] neighbors,
   input  logic       alive,
   output logic       next_alive
);

   // population of the eight surrounding cells
   logic [3:0] count;

   always_comb begin
      count = 4'd0;
      for (int i = 0; i < 8; i++) begin
         count = count + 4'(neighbors[i]);
      end
   end

   // survive on two or three, born on exactly three
   always_comb begin
      if (count == 4'd3) begin
         next_alive = 1'b1;
      end else if (count == 4'd2) begin
         next_alive = alive;
      end else begin
         next_alive = 1'b0;
      end
   end

endmodule

//--- life_grid.sv
`timescale 1ns/1ps

module life_grid #(
   parameter  int rows  = life_pkg::GRID_ROWS,
   parameter  int cols  = life_pkg::GRID_COLS,
   localparam int cells = rows * cols
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             load,
   input  logic             advance,
   input  logic [cells-1:0] initial_state,
   output logic [cells-1:0] grid
);

   logic [cells-1:0] next_grid;

   for (genvar r = 0; r < rows; r++) begin : g_row
      for (genvar c = 0; c < cols; c++) begin : g_col
         logic [7:0] nbr;

         // walk the 3x3 window, skipping the centre
         for (genvar k = 0; k < 8; k++) begin : g_nbr
            localparam int pos = (k < 4) ? k : k + 1;
            localparam int nr  = r + pos / 3 - 1;
            localparam int nc  = c + pos % 3 - 1;

            if (nr >= 0 && nr < rows && nc >= 0 && nc < cols) begin : g_in
               assign nbr[k] = grid[nr * cols + nc];
            end else begin : g_out
               // beyond the border is dead
               assign nbr[k] = 1'b0;
            end
         end

         life_cell cell_i (
            .neighbors  (nbr),
            .alive      (grid[r * cols + c]),
            .next_alive (next_grid[r * cols + c])
         );
      end
   end

   // load wins over advance
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         grid <= '0;
      end else if (load) begin
         grid <= initial_state;
      end else if (advance) begin
         grid <= next_grid;
      end
   end

   // grid holds while neither strobe is high
   grid_hold_a : assert property (
      @(posedge clk) disable iff (reset)
      (!load && !advance) |=> (grid == $past(grid))
   ) else $error("grid changed without load or advance");

endmodule

//--- life_fsm.sv
`timescale 1ns/1ps

module life_fsm (
   input  logic clk,
   input  logic reset,
   input  logic load,
   input  logic run,
   input  logic limit_hit,
   output logic advance,
   output logic running,
   output logic done
);

   life_pkg::run_state_t state;
   life_pkg::run_state_t next_state;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state <= life_pkg::ST_IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      if (load) begin
         // a new pattern always restarts from idle
         next_state = life_pkg::ST_IDLE;
      end else begin
         case (state)
            life_pkg::ST_IDLE,
            life_pkg::ST_PAUSE: begin
               if (run) begin
                  next_state = life_pkg::ST_RUN;
               end
            end
            life_pkg::ST_RUN: begin
               // limit takes priority over a pause request
               if (limit_hit) begin
                  next_state = life_pkg::ST_DONE;
               end else if (!run) begin
                  next_state = life_pkg::ST_PAUSE;
               end
            end
            default: begin
               next_state = state;
            end
         endcase
      end
   end

   assign advance = (state == life_pkg::ST_RUN) && !limit_hit;
   assign running = (state == life_pkg::ST_RUN);
   assign done    = (state == life_pkg::ST_DONE);

   no_advance_done_a : assert property (
      @(posedge clk) disable iff (reset)
      done |-> !advance
   ) else $error("advance high in done state");

endmodule

//--- gen_counter.sv
`timescale 1ns/1ps

module gen_counter (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          load,
   input  logic                          advance,
   input  logic [life_pkg::GEN_WIDTH-1:0] gen_limit,
   output logic [life_pkg::GEN_WIDTH-1:0] generation,
   output logic                          limit_hit
);

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         generation <= '0;
      end else if (load) begin
         generation <= '0;
      end else if (advance) begin
         generation <= generation + 1'b1;
      end
   end

   // zero limit means free running
   assign limit_hit = (gen_limit != '0) && (generation == gen_limit);

   // an advance never carries the count past a nonzero limit
   count_bound_a : assert property (
      @(posedge clk) disable iff (reset)
      (advance && !load && gen_limit != '0) |-> (generation < gen_limit)
   ) else $error("generation count would exceed gen_limit");

endmodule

//--- game_of_life.sv
`timescale 1ns/1ps

module game_of_life #(
   parameter  int rows  = life_pkg::GRID_ROWS,
   parameter  int cols  = life_pkg::GRID_COLS,
   localparam int cells = rows * cols
) (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [cells-1:0]              initial_state,
   input  logic                          load,
   input  logic                          run,
   input  logic [life_pkg::GEN_WIDTH-1:0] gen_limit,
   output logic [cells-1:0]              grid,
   output logic [life_pkg::GEN_WIDTH-1:0] generation,
   output logic                          running,
   output logic                          done
);

   logic advance;
   logic limit_hit;

   life_fsm fsm_i (
      .clk       (clk),
      .reset     (reset),
      .load      (load),
      .run       (run),
      .limit_hit (limit_hit),
      .advance   (advance),
      .running   (running),
      .done      (done)
   );

   gen_counter counter_i (
      .clk        (clk),
      .reset      (reset),
      .load       (load),
      .advance    (advance),
      .gen_limit  (gen_limit),
      .generation (generation),
      .limit_hit  (limit_hit)
   );

   life_grid #(
      .rows (rows),
      .cols (cols)
   ) grid_i (
      .clk           (clk),
      .reset         (reset),
      .load          (load),
      .advance       (advance),
      .initial_state (initial_state),
      .grid          (grid)
   );

endmodule

//--- tb_game_of_life.sv
`timescale 1ns/1ps

module tb_game_of_life;

   localparam int rows = life_pkg::GRID_ROWS;
   localparam int cols = life_pkg::GRID_COLS;
   localparam int cells = rows * cols;
   localparam int timeout_cycles = 2000;

   typedef logic [cells-1:0] grid_t;
   typedef logic [life_pkg::GEN_WIDTH-1:0] count_t;

   logic   clk;
   logic   reset;
   grid_t  initial_state;
   logic   load;
   logic   run;
   count_t gen_limit;
   grid_t  grid;
   count_t generation;
   logic   running;
   logic   done;

   int cycles = 0;

   game_of_life #(
      .rows (rows),
      .cols (cols)
   ) game_of_life_i (
      .clk           (clk),
      .reset         (reset),
      .initial_state (initial_state),
      .load          (load),
      .run           (run),
      .gen_limit     (gen_limit),
      .grid          (grid),
      .generation    (generation),
      .running       (running),
      .done          (done)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout: the run did not finish within %0d cycles", timeout_cycles);
         $display(">>> FAIL");
         $fatal(1, "simulation timeout");
      end
   end

   // one generation with dead cells beyond the border
   function automatic grid_t life_step(input grid_t g);
      grid_t n;
      int cnt;
      int rr;
      int cc;
      n = '0;
      for (int r = 0; r < rows; r++) begin
         for (int c = 0; c < cols; c++) begin
            cnt = 0;
            for (int dr = -1; dr <= 1; dr++) begin
               for (int dc = -1; dc <= 1; dc++) begin
                  rr = r + dr;
                  cc = c + dc;
                  if ((dr != 0 || dc != 0) && rr >= 0 && rr < rows && cc >= 0 && cc < cols) begin
                     cnt = cnt + int'(g[rr * cols + cc]);
                  end
               end
            end
            n[r * cols + c] = (cnt == 3) || (cnt == 2 && g[r * cols + c]);
         end
      end
      return n;
   endfunction

   function automatic grid_t life_steps(input grid_t g, input int n);
      grid_t s;
      s = g;
      for (int i = 0; i < n; i++) begin
         s = life_step(s);
      end
      return s;
   endfunction

   function automatic grid_t set_cell(input grid_t g, input int r, input int c);
      grid_t s;
      s = g;
      s[r * cols + c] = 1'b1;
      return s;
   endfunction

   task automatic compare_grid(input string name, input grid_t got, input grid_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
         $display(">>> FAIL");
         $fatal(1, "grid mismatch");
      end
   endtask

   task automatic compare_count(input string name, input count_t got, input count_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
         $display(">>> FAIL");
         $fatal(1, "count mismatch");
      end
   endtask

   task automatic compare_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %b, expected %b", $time, name, got, exp);
         $display(">>> FAIL");
         $fatal(1, "flag mismatch");
      end
   endtask

   // inputs change and outputs are read just after the edge
   task automatic tick();
      @(posedge clk);
      #2;
   endtask

   task automatic load_pattern(input grid_t pat, input count_t limit);
      initial_state = pat;
      gen_limit = limit;
      load = 1'b1;
      tick();
      load = 1'b0;
   endtask

   task automatic wait_done();
      while (!done) begin
         tick();
      end
   endtask

   task automatic test_reset();
      compare_grid("grid", grid, '0);
      compare_count("generation", generation, '0);
      compare_flag("running", running, 1'b0);
      compare_flag("done", done, 1'b0);
   endtask

   task automatic test_blinker_block();
      grid_t pat;
      pat = '0;
      pat = set_cell(pat, 3, 4);
      pat = set_cell(pat, 3, 5);
      pat = set_cell(pat, 3, 6);
      pat = set_cell(pat, 10, 10);
      pat = set_cell(pat, 10, 11);
      pat = set_cell(pat, 11, 10);
      pat = set_cell(pat, 11, 11);
      load_pattern(pat, 16'd1);
      run = 1'b1;
      wait_done();
      compare_grid("grid", grid, life_step(pat));
      compare_count("generation", generation, 16'd1);
      // period two, so two steps bring the start back
      load_pattern(pat, 16'd2);
      wait_done();
      compare_grid("grid", grid, pat);
      compare_count("generation", generation, 16'd2);
      run = 1'b0;
   endtask

   task automatic test_border();
      grid_t pat;
      pat = '0;
      // glider heading for the top-left corner
      pat = set_cell(pat, 5, 5);
      pat = set_cell(pat, 5, 6);
      pat = set_cell(pat, 5, 7);
      pat = set_cell(pat, 6, 5);
      pat = set_cell(pat, 7, 6);
      load_pattern(pat, 16'd40);
      run = 1'b1;
      wait_done();
      compare_grid("grid", grid, life_steps(pat, 40));
      compare_count("generation", generation, 16'd40);
      run = 1'b0;
   endtask

   task automatic test_pause();
      grid_t pat;
      grid_t held;
      count_t n;
      pat = '0;
      // r-pentomino keeps changing for a long time
      pat = set_cell(pat, 7, 8);
      pat = set_cell(pat, 7, 9);
      pat = set_cell(pat, 8, 7);
      pat = set_cell(pat, 8, 8);
      pat = set_cell(pat, 9, 8);
      load_pattern(pat, 16'd0);
      run = 1'b1;
      repeat (7) tick();
      compare_flag("done", done, 1'b0);
      run = 1'b0;
      while (running) begin
         tick();
      end
      n = generation;
      compare_grid("grid", grid, life_steps(pat, int'(n)));
      held = grid;
      repeat (5) begin
         tick();
         compare_grid("grid", grid, held);
         compare_count("generation", generation, n);
         compare_flag("done", done, 1'b0);
      end
      run = 1'b1;
      while (!running) begin
         tick();
      end
      repeat (3) tick();
      compare_flag("generation rising", generation > n, 1'b1);
      compare_flag("done", done, 1'b0);
      run = 1'b0;
      while (running) begin
         tick();
      end
   endtask

   task automatic test_random();
      grid_t pat;
      for (int i = 0; i < cells / 32; i++) begin
         pat[i * 32 +: 32] = $urandom;
      end
      load_pattern(pat, 16'd5);
      run = 1'b1;
      wait_done();
      compare_grid("grid", grid, life_steps(pat, 5));
      compare_count("generation", generation, 16'd5);
      run = 1'b0;
   endtask

   task automatic test_load_during_run();
      grid_t first;
      grid_t second;
      first = '0;
      first = set_cell(first, 2, 2);
      first = set_cell(first, 2, 3);
      first = set_cell(first, 2, 4);
      second = '0;
      second = set_cell(second, 12, 1);
      second = set_cell(second, 13, 2);
      second = set_cell(second, 14, 0);
      second = set_cell(second, 14, 1);
      second = set_cell(second, 14, 2);
      load_pattern(first, 16'd0);
      run = 1'b1;
      repeat (4) tick();
      compare_flag("running", running, 1'b1);
      // run stays high, so only the load can leave the run state
      load_pattern(second, 16'd0);
      compare_count("generation", generation, 16'd0);
      compare_flag("running", running, 1'b0);
      compare_grid("grid", grid, second);
      run = 1'b0;
      repeat (3) tick();
      compare_grid("grid", grid, second);
   endtask

   initial begin
      void'($urandom(32'hc63f));
      reset = 1'b1;
      initial_state = '0;
      load = 1'b0;
      run = 1'b0;
      gen_limit = '0;
      repeat (16) @(posedge clk);
      #2;
      reset = 1'b0;
      tick();
      test_reset();
      test_blinker_block();
      test_border();
      test_pause();
      test_random();
      test_load_during_run();
      $display(">>> PASS");
      $finish;
   end

endmodule

//--- sim.f
life_pkg.sv
life_cell.sv
life_grid.sv
life_fsm.sv
gen_counter.sv
game_of_life.sv
tb_game_of_life.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module tb_game_of_life -o tb_sim

out=$(./obj_dir/tb_sim)
echo "$out"

echo "$out" | grep -q '^>>> PASS$'
